// File: common/hack_defs.svh
`ifndef HACK_DEFS_SVH
`define HACK_DEFS_SVH

// ************************************************************************
// datapath widths
// ************************************************************************

// width of one data word and of the A and D registers
`define HACK_DATA_W      16
// width of a RAM address and of the constant in an A-instruction
`define HACK_ADDR_W      15
// width of the program counter
`define HACK_PC_W        15
// a ROM word carries two instructions so its address drops pc bit 0
`define HACK_FETCH_W     14

// ************************************************************************
// instruction buffering
// ************************************************************************

`define HACK_FIFO_DEPTH  8
// the count must reach 8 so it is one bit wider than the pointers
`define HACK_FIFO_CNT_W  4
// fetch pauses at this depth and the word still in flight fits behind it
`define HACK_FETCH_AHEAD 4

`endif

// File: common/hack_pkg.sv
`default_nettype none

package hack_pkg;

`include "hack_defs.svh"

    // an A-instruction only loads its 15-bit constant into A
    typedef struct packed {
        logic                    is_c;
        logic [`HACK_ADDR_W-1:0] value;
    } hack_a_inst_t;

    // compute instruction in the usual 111a cccc ccdd djjj layout
    typedef struct packed {
        logic       is_c;
        logic [1:0] unused;
        logic       am;
        logic [5:0] comp;
        logic       dest_a;
        logic       dest_d;
        logic       dest_m;
        logic       jlt;
        logic       jeq;
        logic       jgt;
    } hack_c_inst_t;

    // bit 15 tells which of the two readings applies to the word
    typedef union packed {
        hack_a_inst_t a;
        hack_c_inst_t c;
    } hack_inst_t;

    // slot 0 is the instruction at the even pc
    typedef hack_inst_t [1:0] rom_word_t;

    // one issued item handed from decode to execute
    typedef struct packed {
        logic                    valid;
        logic                    has_const;
        logic [`HACK_ADDR_W-1:0] const_value;
        logic                    has_comp;
        hack_c_inst_t            c;
        logic [1:0]              pc_inc;
    } issue_op_t;

    typedef struct packed {
        logic                  valid;
        logic [`HACK_PC_W-1:0] pc;
    } redirect_t;

    typedef struct packed {
        logic                    en;
        logic [`HACK_ADDR_W-1:0] addr;
        logic [`HACK_DATA_W-1:0] data;
    } mem_wr_t;

endpackage

`default_nettype wire

// File: fetch/inst_prefetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "hack_defs.svh"

module inst_prefetch (
    input  logic                        clk,
    input  logic                        resetN,
    input  hack_pkg::redirect_t         redirect,
    input  logic [`HACK_FIFO_CNT_W-1:0] depth,
    input  hack_pkg::rom_word_t         inst,
    output logic [`HACK_FETCH_W-1:0]    inst_addr,
    output logic                        push,
    output hack_pkg::rom_word_t         push_word
);

    localparam int FETCH_W = `HACK_FETCH_W;
    localparam int CNT_W = `HACK_FIFO_CNT_W;
    localparam logic [CNT_W-1:0] AHEAD = CNT_W'(`HACK_FETCH_AHEAD);

    // next word address to request when the FIFO has room
    logic [FETCH_W-1:0] addr_q;
    // set when the ROM output in this cycle answers a request
    logic               in_flight_q;
    logic               issue;

    // fetch is purely sequential and only the execute stage moves it elsewhere
    // a redirect always requests because the FIFO empties on the same edge
    assign issue = redirect.valid || (depth < AHEAD);

    // the target word goes out in the redirect cycle itself
    assign inst_addr = redirect.valid ? redirect.pc[`HACK_PC_W-1:1] : addr_q;

    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
        begin
            addr_q <= '0;
            in_flight_q <= 1'b0;
        end
        else
        begin
            if (issue)
                addr_q <= inst_addr + FETCH_W'(1);
            // the ROM answers one cycle later so the flag follows the request
            in_flight_q <= issue;
        end
    end

    // a word that was asked for before the redirect is thrown away here
    assign push = in_flight_q && !redirect.valid;
    assign push_word = inst;

endmodule

`default_nettype wire

// File: fetch/inst_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module inst_fifo #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 32
) (
    input  logic                         clk,
    input  logic                         resetN,
    input  logic                         push,
    input  logic [WIDTH-1:0]             wdata,
    input  logic                         pop,
    input  logic                         flush,
    output logic [WIDTH-1:0]             rdata,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   depth
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // pointers wrap at DEPTH even when it is not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    // flush wins over push and pop that arrive in the same cycle
    assign do_push = push && !flush && (count_q != CNT_W'(DEPTH));
    assign do_pop = pop && !flush && !empty;

    // show-ahead read so the head is there before any pop
    assign rdata = mem[rd_ptr_q];
    assign empty = (count_q == '0);
    assign depth = count_q;

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr_q] <= wdata;
    end

    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end
        else if (flush)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (do_pop)
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            // simultaneous push and pop leave the count unchanged
            if (do_push && !do_pop)
                count_q <= count_q + CNT_W'(1);
            else if (do_pop && !do_push)
                count_q <= count_q - CNT_W'(1);
        end
    end

endmodule

`default_nettype wire

// File: core/hack_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "hack_defs.svh"

module hack_alu (
    input  logic [`HACK_DATA_W-1:0] x,
    input  logic [`HACK_DATA_W-1:0] y,
    input  logic [5:0]              fn,
    output logic [`HACK_DATA_W-1:0] out,
    output logic                    zero
);

    logic [`HACK_DATA_W-1:0] xz;
    logic [`HACK_DATA_W-1:0] xn;
    logic [`HACK_DATA_W-1:0] yz;
    logic [`HACK_DATA_W-1:0] yn;
    logic [`HACK_DATA_W-1:0] f;

    // fn is zx nx zy ny f no from the top bit down
    always_comb
    begin
        xz = fn[5] ? '0 : x;
        xn = fn[4] ? ~xz : xz;
        yz = fn[3] ? '0 : y;
        yn = fn[2] ? ~yz : yz;
        // f chooses between add and bitwise and
        f = fn[1] ? (xn + yn) : (xn & yn);
        out = fn[0] ? ~f : f;
    end

    assign zero = (out == '0);

endmodule

`default_nettype wire

// File: core/issue_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "hack_defs.svh"

module issue_decode (
    input  logic                    clk,
    input  logic                    resetN,
    input  hack_pkg::rom_word_t     head,
    input  logic                    empty,
    input  hack_pkg::redirect_t     redirect,
    input  logic [`HACK_DATA_W-1:0] a_next,
    output logic                    pop,
    output logic [`HACK_ADDR_W-1:0] read_addr,
    output hack_pkg::issue_op_t     op
);

    // which slot of the head word is decoded next
    logic                 half_q;
    hack_pkg::hack_inst_t cur;
    logic                 pair;
    logic                 take;
    hack_pkg::issue_op_t  op_d;

    assign cur = head[half_q];

    // ************************************************************************
    // pairing and FIFO pop
    // ************************************************************************

    // only an A-instruction in slot 0 followed by a C-instruction in slot 1
    // is issued together, which is the common load-then-compute sequence
    assign pair = !half_q && !head[0].a.is_c && head[1].c.is_c;

    // nothing is taken in a redirect cycle since the head is stale
    assign take = !empty && !redirect.valid;

    // the word is consumed once its last slot has been issued
    assign pop = take && (pair || half_q);

    // the RAM address leaves in this cycle so M data is ready in execute
    // a pair carries its own address, otherwise it is A after the coming edge
    assign read_addr = pair ? head[0].a.value : a_next[`HACK_ADDR_W-1:0];

    // ************************************************************************
    // decode into one issue item
    // ************************************************************************

    always_comb
    begin
        op_d = '0;
        op_d.valid = take;
        if (pair)
        begin
            op_d.has_const = 1'b1;
            op_d.const_value = head[0].a.value;
            op_d.has_comp = 1'b1;
            op_d.c = head[1].c;
            op_d.pc_inc = 2'd2;
        end
        else
        begin
            // a lone instruction is read both ways and is_c picks the view
            op_d.has_const = !cur.a.is_c;
            op_d.const_value = cur.a.value;
            op_d.has_comp = cur.c.is_c;
            op_d.c = cur.c;
            op_d.pc_inc = 2'd1;
        end
    end

    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
        begin
            half_q <= 1'b0;
            op <= '0;
        end
        else
        begin
            // a jump target at an odd pc starts decoding on slot 1
            if (redirect.valid)
                half_q <= redirect.pc[0];
            else if (take)
                half_q <= pair ? 1'b0 : !half_q;
            op <= op_d;
        end
    end

endmodule

`default_nettype wire

// File: core/execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "hack_defs.svh"

module execute (
    input  logic                    clk,
    input  logic                    resetN,
    input  hack_pkg::issue_op_t     op,
    input  logic [`HACK_ADDR_W-1:0] read_addr,
    input  logic [`HACK_DATA_W-1:0] in_m,
    output logic [`HACK_DATA_W-1:0] a_next,
    output hack_pkg::redirect_t     redirect,
    output hack_pkg::mem_wr_t       mem_wr
);

    localparam int DW = `HACK_DATA_W;
    localparam int AW = `HACK_ADDR_W;
    localparam int PW = `HACK_PC_W;

    logic [DW-1:0] a_q;
    logic [DW-1:0] d_q;
    // read address and write port of the previous cycle for the bypass
    logic [AW-1:0] rd_addr_q;
    logic          wr_en_q;
    logic [AW-1:0] wr_addr_q;
    logic [DW-1:0] wr_data_q;
    logic          comp_en;
    logic          pair;
    logic          bypass;
    logic [DW-1:0] konst;
    logic [DW-1:0] y;
    logic [DW-1:0] alu_out;
    logic          zero;
    logic          neg;
    logic          cond;

    assign comp_en = op.valid && op.has_comp;
    assign pair = op.has_const && op.has_comp;
    assign konst = {1'b0, op.const_value};

    // ************************************************************************
    // ALU operands
    // ************************************************************************

    // the RAM is read-first so a write to the same address one cycle
    // earlier is not in in_m yet and has to come from the write register
    assign bypass = wr_en_q && (wr_addr_q == rd_addr_q);

    // in a pair the A half has not reached the register yet
    assign y = op.c.am ? (bypass ? wr_data_q : in_m) : (pair ? konst : a_q);

    hack_alu u_alu (
        .x    (d_q),
        .y    (y),
        .fn   (op.c.comp),
        .out  (alu_out),
        .zero (zero)
    );

    assign neg = alu_out[DW-1];
    assign cond = (op.c.jlt && neg) || (op.c.jeq && zero) || (op.c.jgt && !neg && !zero);

    // ************************************************************************
    // results, jump and RAM write
    // ************************************************************************

    // the jump target and the M address both use A from before this op
    assign redirect.valid = comp_en && cond;
    assign redirect.pc = pair ? op.const_value : a_q[PW-1:0];

    assign mem_wr.en = comp_en && op.c.dest_m;
    assign mem_wr.addr = pair ? op.const_value : a_q[AW-1:0];
    assign mem_wr.data = alu_out;

    // decode needs A as it will be after this edge to address the RAM
    always_comb
    begin
        a_next = a_q;
        if (comp_en && op.c.dest_a)
            a_next = alu_out;
        else if (op.valid && op.has_const)
            a_next = konst;
    end

    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
        begin
            a_q <= '0;
            d_q <= '0;
            wr_en_q <= 1'b0;
        end
        else
        begin
            a_q <= a_next;
            if (comp_en && op.c.dest_d)
                d_q <= alu_out;
            wr_en_q <= mem_wr.en;
        end
    end

    always_ff @(posedge clk)
    begin
        rd_addr_q <= read_addr;
        wr_addr_q <= mem_wr.addr;
        wr_data_q <= mem_wr.data;
    end

endmodule

`default_nettype wire

// File: design/hack_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "hack_defs.svh"

module hack_cpu (
    input  logic                     clk,
    input  logic                     resetN,
    output logic [`HACK_FETCH_W-1:0] inst_addr,
    input  hack_pkg::rom_word_t      inst,
    output logic [`HACK_ADDR_W-1:0]  read_addr,
    input  logic [`HACK_DATA_W-1:0]  in_m,
    output hack_pkg::mem_wr_t        mem_wr
);

    // taken-jump pulse from execute to fetch, FIFO and decode
    hack_pkg::redirect_t         redirect;
    logic [`HACK_FIFO_CNT_W-1:0] fifo_depth;
    logic                        push;
    hack_pkg::rom_word_t         push_word;
    logic                        pop;
    logic                        empty;
    hack_pkg::rom_word_t         head;
    hack_pkg::issue_op_t         op;
    logic [`HACK_DATA_W-1:0]     a_next;

    inst_prefetch u_inst_prefetch (
        .clk       (clk),
        .resetN    (resetN),
        .redirect  (redirect),
        .depth     (fifo_depth),
        .inst      (inst),
        .inst_addr (inst_addr),
        .push      (push),
        .push_word (push_word)
    );

    // a redirect doubles as the flush of everything fetched so far
    inst_fifo #(
        .DEPTH (`HACK_FIFO_DEPTH),
        .WIDTH ($bits(hack_pkg::rom_word_t))
    ) u_inst_fifo (
        .clk    (clk),
        .resetN (resetN),
        .push   (push),
        .wdata  (push_word),
        .pop    (pop),
        .flush  (redirect.valid),
        .rdata  (head),
        .empty  (empty),
        .depth  (fifo_depth)
    );

    issue_decode u_issue_decode (
        .clk       (clk),
        .resetN    (resetN),
        .head      (head),
        .empty     (empty),
        .redirect  (redirect),
        .a_next    (a_next),
        .pop       (pop),
        .read_addr (read_addr),
        .op        (op)
    );

    execute u_execute (
        .clk       (clk),
        .resetN    (resetN),
        .op        (op),
        .read_addr (read_addr),
        .in_m      (in_m),
        .a_next    (a_next),
        .redirect  (redirect),
        .mem_wr    (mem_wr)
    );

endmodule

`default_nettype wire

// File: tests/tb_hack_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "hack_defs.svh"

module tb_hack_cpu;

    // comp field values with the a bit clear
    localparam logic [5:0] C_ZERO = 6'b101010;
    localparam logic [5:0] C_NEG1 = 6'b111010;
    localparam logic [5:0] C_D = 6'b001100;
    localparam logic [5:0] C_A = 6'b110000;
    localparam logic [5:0] C_DP1 = 6'b011111;
    localparam logic [5:0] C_DM1 = 6'b001110;
    localparam logic [5:0] C_AP1 = 6'b110111;
    localparam logic [5:0] C_ONE = 6'b111111;
    localparam logic [5:0] COMPS [18] = '{6'b101010, 6'b111111, 6'b111010, 6'b001100,
        6'b110000, 6'b001101, 6'b110001, 6'b001111, 6'b110011, 6'b011111, 6'b110111,
        6'b001110, 6'b110010, 6'b000010, 6'b010011, 6'b000111, 6'b000000, 6'b010101};

    logic                           clk;
    logic                           resetN;
    logic [`HACK_FETCH_W-1:0]       inst_addr;
    hack_pkg::rom_word_t            inst;
    logic [`HACK_ADDR_W-1:0]        read_addr;
    logic [`HACK_DATA_W-1:0]        in_m;
    hack_pkg::mem_wr_t              mem_wr;

    logic [15:0] prog [0:32767];
    logic [15:0] ram [0:32767];
    logic [15:0] ref_ram [0:32767];
    hack_pkg::rom_word_t rom_q;
    logic [15:0] ram_q;
    logic [14:0] exp_addr [$];
    logic [15:0] exp_data [$];
    logic [31:0] rng;
    int          prog_len;
    int          steps;
    int          errors;
    int          tests_run;
    logic        timed_out;
    // high once an edge with reset released has gone by
    logic        released_q;

    hack_cpu u_hack_cpu (
        .clk       (clk),
        .resetN    (resetN),
        .inst_addr (inst_addr),
        .inst      (inst),
        .read_addr (read_addr),
        .in_m      (in_m),
        .mem_wr    (mem_wr)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ************************************************************************
    // ROM and RAM models with one cycle of read latency
    // ************************************************************************

    always @(posedge clk)
    begin
        rom_q <= {prog[{inst_addr, 1'b1}], prog[{inst_addr, 1'b0}]};
        // read-first so a write in the same cycle is not seen yet
        ram_q <= ram[read_addr];
        if (resetN && mem_wr.en)
            ram[mem_wr.addr] <= mem_wr.data;
    end

    always @(negedge clk)
    begin
        inst = rom_q;
        in_m = ram_q;
    end

    // every write is compared in order against the interpreter's list
    always @(posedge clk)
    begin
        // the strobe stays low in reset and on the first edge after it
        if (!resetN || !released_q)
        begin
            assert (!mem_wr.en)
            else
            begin
                $display("write strobe raised in or right after reset at %0t", $time);
                errors++;
            end
            assert (inst_addr == '0)
            else
            begin
                $display("MISMATCH %0t inst_addr got %h expected 0", $time, inst_addr);
                errors++;
            end
        end
        else if (mem_wr.en)
        begin
            if (exp_addr.size() == 0)
            begin
                $display("unexpected RAM write to %h at %0t", mem_wr.addr, $time);
                errors++;
            end
            else
            begin
                assert (mem_wr.addr == exp_addr[0])
                else
                begin
                    $display("MISMATCH %0t mem_wr.addr got %h expected %h",
                             $time, mem_wr.addr, exp_addr[0]);
                    errors++;
                end
                assert (mem_wr.data == exp_data[0])
                else
                begin
                    $display("MISMATCH %0t mem_wr.data got %h expected %h",
                             $time, mem_wr.data, exp_data[0]);
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
        released_q <= resetN;
    end

    // ************************************************************************
    // program building and the reference interpreter
    // ************************************************************************

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic emit_a(input logic [14:0] value);
        prog[prog_len] = {1'b0, value};
        prog_len++;
    endtask

    // dest is A D M and jmp is lt eq gt as in the usual encoding
    task automatic emit_c(input logic am, input logic [5:0] comp, input logic [2:0] dest,
                          input logic [2:0] jmp);
        prog[prog_len] = {3'b111, am, comp, dest, jmp};
        prog_len++;
    endtask

    // pads with a no-op so the next A-instruction sits at an even pc
    task automatic align_even();
        if (prog_len % 2 == 1)
            emit_c(1'b0, C_ZERO, 3'b000, 3'b000);
    endtask

    // the eighteen entries of the Hack comp table, x is D and y is A or M
    function automatic logic [15:0] comp_fn(input logic [15:0] x, input logic [15:0] y,
                                            input logic [5:0] c);
        case (c)
            6'b101010: return 16'd0;
            6'b111111: return 16'd1;
            6'b111010: return 16'hffff;
            6'b001100: return x;
            6'b110000: return y;
            6'b001101: return ~x;
            6'b110001: return ~y;
            6'b001111: return -x;
            6'b110011: return -y;
            6'b011111: return x + 16'd1;
            6'b110111: return y + 16'd1;
            6'b001110: return x - 16'd1;
            6'b110010: return y - 16'd1;
            6'b000010: return x + y;
            6'b010011: return x - y;
            6'b000111: return y - x;
            6'b000000: return x & y;
            6'b010101: return x | y;
            default: return 'x;
        endcase
    endfunction

    // runs the program one instruction at a time up to the halt loop
    task automatic interpret(input int halt_pc);
        logic [15:0] a;
        logic [15:0] d;
        logic [15:0] i;
        logic [15:0] r;
        logic        tk;
        int          pc;
        a = '0;
        d = '0;
        pc = 0;
        steps = 0;
        while (pc != halt_pc && steps < 5000)
        begin
            i = prog[pc];
            steps++;
            if (!i[15])
            begin
                a = i;
                pc++;
            end
            else
            begin
                r = comp_fn(d, i[12] ? ref_ram[a[14:0]] : a, i[11:6]);
                if (i[3])
                begin
                    ref_ram[a[14:0]] = r;
                    exp_addr.push_back(a[14:0]);
                    exp_data.push_back(r);
                end
                tk = (i[2] && r[15]) || (i[1] && r == 0) || (i[0] && !r[15] && r != 0);
                pc = tk ? int'(a[14:0]) : pc + 1;
                if (i[4])
                    d = r;
                if (i[5])
                    a = r;
            end
        end
    endtask

    // ************************************************************************
    // test sequencing
    // ************************************************************************

    task automatic start_program();
        for (int k = 0; k < 32768; k++)
            prog[k] = '0;
        prog_len = 0;
    endtask

    task automatic run_test(input string name);
        int halt_pc;
        int cycles;
        int limit;
        int err0;
        align_even();
        halt_pc = prog_len;
        emit_a(15'(halt_pc));
        emit_c(1'b0, C_ZERO, 3'b000, 3'b111);
        // the fill pattern mixes every address bit
        for (int k = 0; k < 32768; k++)
        begin
            ram[k] = 16'(k * 40503) ^ 16'(k >> 5);
            ref_ram[k] = ram[k];
        end
        exp_addr.delete();
        exp_data.delete();
        interpret(halt_pc);
        err0 = errors;
        @(negedge clk);
        resetN = 1'b0;
        repeat (2) @(negedge clk);
        resetN = 1'b1;
        limit = 4 * steps + 200;
        cycles = 0;
        while (exp_addr.size() != 0 && !timed_out)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > limit)
                timed_out = 1'b1;
        end
        // a short window past the last write catches stray writes
        repeat (20) @(posedge clk);
        tests_run++;
        if (timed_out)
            $display("test %s timed out with %0d writes missing", name, exp_addr.size());
        else
            $display("test %s done, %0d errors", name, errors - err0);
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] s;
        resetN = 1'b0;
        inst = '0;
        in_m = '0;
        rng = 32'ha138b27c;
        errors = 0;
        tests_run = 0;
        timed_out = 1'b0;

        // every comp code with a constant operand and then an M operand
        start_program();
        for (int k = 0; k < 18; k++)
        begin
            r = next_rand();
            s = next_rand();
            align_even();
            emit_a(r[14:0]);
            emit_c(1'b0, C_A, 3'b010, 3'b000);
            emit_a(15'h0200 + 15'(s[7:0]));
            emit_c(1'b0, COMPS[k], 3'b001, 3'b000);
            emit_c(1'b1, COMPS[k], 3'b001, 3'b000);
        end
        run_test("paired");

        // odd alignment and chains of C-instructions
        start_program();
        emit_c(1'b0, C_NEG1, 3'b010, 3'b000);
        emit_a(15'h0310);
        emit_c(1'b0, C_DP1, 3'b011, 3'b000);
        emit_c(1'b0, C_DP1, 3'b001, 3'b000);
        for (int k = 0; k < 12; k++)
        begin
            r = next_rand();
            emit_a(r[14:0]);
            emit_c(r[15], COMPS[r[20:16] % 18], (r[17] ? 3'b011 : 3'b001), 3'b000);
            if (r[22])
                emit_c(1'b1, COMPS[r[27:23] % 18], (r[28] ? 3'b101 : 3'b001), 3'b000);
        end
        run_test("odd_align");

        // M read right after a write to it, lone and paired
        start_program();
        emit_a(15'h0040);
        emit_c(1'b0, C_DP1, 3'b001, 3'b000);
        emit_c(1'b1, C_AP1, 3'b011, 3'b000);
        emit_c(1'b1, C_AP1, 3'b001, 3'b000);
        emit_a(15'h0040);
        emit_c(1'b1, C_A, 3'b010, 3'b000);
        emit_a(15'h0041);
        emit_c(1'b0, C_D, 3'b001, 3'b000);
        emit_a(15'h0041);
        emit_c(1'b1, C_AP1, 3'b011, 3'b000);
        run_test("read_after_write");

        // countdown loop then taken and untaken jumps at both alignments
        start_program();
        emit_a(15'd5);
        emit_c(1'b0, C_A, 3'b010, 3'b000);
        emit_a(15'd100);
        emit_c(1'b0, C_D, 3'b001, 3'b000);
        emit_c(1'b0, C_DM1, 3'b010, 3'b000);
        emit_a(15'd2);
        emit_c(1'b0, C_D, 3'b000, 3'b001);
        emit_a(15'd11);
        emit_c(1'b0, C_D, 3'b000, 3'b100);
        emit_a(15'd13);
        emit_c(1'b0, C_D, 3'b000, 3'b010);
        emit_a(15'd101);
        emit_c(1'b0, C_NEG1, 3'b001, 3'b000);
        emit_c(1'b0, C_DM1, 3'b010, 3'b000);
        emit_a(15'd200);
        emit_c(1'b0, C_D, 3'b001, 3'b000);
        emit_a(15'd19);
        emit_c(1'b0, C_D, 3'b000, 3'b100);
        emit_c(1'b0, C_ONE, 3'b001, 3'b000);
        emit_c(1'b0, C_DP1, 3'b001, 3'b000);
        emit_a(15'd3);
        emit_c(1'b0, C_D, 3'b000, 3'b001);
        run_test("jumps");

        $display("%0d tests run, %0d errors, timeout %0d", tests_run, errors, timed_out);
        if (errors == 0 && !timed_out)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/hack_pkg.sv
fetch/inst_prefetch.sv
fetch/inst_fifo.sv
core/hack_alu.sv
core/issue_decode.sv
core/execute.sv
design/hack_cpu.sv
tests/tb_hack_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_hack_cpu
FLAGS ?= --binary --timing
BUILD ?= obj_dir

.PHONY: test clean help

help:
	@echo "targets: test (build and run the simulation), clean (remove $(BUILD)), help"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f tb.f
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(BUILD)
